/* Makefile */
VERILATOR ?= verilator
TOP       ?= guess_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

/* bench/guess_checks.svh */
////////////////////////////////////////////////////////////
// reference rules and compare tasks for guess_tb
////////////////////////////////////////////////////////////

function automatic bcd_guess_t to_bcd(input int value);
    bcd_guess_t r;
    r.bcd.tens = 4'(value / 10);
    r.bcd.ones = 4'(value % 10);
    return r;
endfunction

// only a guess strictly between the bounds moves one of them
function automatic logic judge_guess(
    input  bcd_guess_t ans,
    input  bcd_guess_t guess,
    input  bcd_guess_t lo,
    input  bcd_guess_t hi,
    output bcd_guess_t new_lo,
    output bcd_guess_t new_hi
);
    logic hit;
    new_lo = lo;
    new_hi = hi;
    hit    = 1'b0;
    if (guess.raw > lo.raw && guess.raw < hi.raw) begin
        if (guess.raw == ans.raw) begin
            hit = 1'b1;
        end else if (guess.raw < ans.raw) begin
            new_lo = guess;
        end else begin
            new_hi = guess;
        end
    end
    return hit;
endfunction

// segments back to a nibble
// E marks a pattern that is not in the table
function automatic logic [3:0] seg_to_nibble(input logic [6:0] seg);
    logic [3:0] n;
    n = 4'hE;
    for (int i = 0; i < 10; i++) begin
        if (SEG_PATTERNS[i] == seg) n = 4'(i);
    end
    if (seg == SEG_PATTERNS[10]) n = SEG_BLANK_CODE;
    return n;
endfunction

task automatic check_value(input string what, input bcd_guess_t got, input bcd_guess_t exp);
    checks++;
    if (got.raw !== exp.raw) begin
        errors++;
        $display("[ERROR] %0t ns: %s shows %02h, expected %02h", $time, what, got.raw, exp.raw);
    end
endtask

task automatic check_segments(input string what, input logic [6:0] got, input logic [6:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t ns: %s segments %07b, expected %07b", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// segments of one digit position while its line is active
task automatic sample_digit(input int idx, output logic [6:0] seg);
    int waited;
    waited = 0;
    next_cycle();
    while (digit[idx] !== 1'b0 && waited < 2 * SCAN_DIV * NUM_DIGITS) begin
        next_cycle();
        waited++;
    end
    if (digit[idx] !== 1'b0) begin
        seg = 7'h00;
        abort_run($sformatf("digit line %0d was never scanned", idx));
    end else begin
        seg = display;
    end
endtask

task automatic read_pair(input int left, output bcd_guess_t value);
    logic [6:0] seg;
    sample_digit(left, seg);
    value.bcd.tens = seg_to_nibble(seg);
    sample_digit(left - 1, seg);
    value.bcd.ones = seg_to_nibble(seg);
endtask

/* bench/guess_tb.sv */
`timescale 1ns/1ns

module guess_tb
    import guess_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  cheat;
    logic [7:0]            scan_code;
    logic                  code_req;
    logic                  code_ack;
    logic                  win;
    logic [NUM_DIGITS-1:0] digit;
    logic [6:0]            display;

    int         errors;
    int         checks;
    int         tests_run;
    int         err_mark;
    int         edge_count;
    bcd_guess_t answer;
    bcd_guess_t lower;
    bcd_guess_t upper;

    guess_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cheat     (cheat),
        .scan_code (scan_code),
        .code_req  (code_req),
        .code_ack  (code_ack),
        .win       (win),
        .digit     (digit),
        .display   (display)
    );

    always #20 clk = ~clk;

    // edges since reset release
    // the answer counter follows this count
    always @(posedge clk or posedge rst) begin
        if (rst) edge_count <= 0;
        else edge_count <= edge_count + 1;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string reason);
        errors++;
        $display("%0t ns: %s, run stopped", $time, reason);
        $display("Test failed");
        $finish;
    endtask

    `include "guess_checks.svh"

    ////////////////////////////////////////////////////////////
    // keyboard side
    ////////////////////////////////////////////////////////////

    // one byte over the four-phase port
    task automatic send_byte(input logic [7:0] code);
        int waited;
        waited = 0;
        while (code_ack !== 1'b0 && waited < 16) begin
            next_cycle();
            waited++;
        end
        if (code_ack !== 1'b0) abort_run("code_ack stayed high before a new byte");
        scan_code = code;
        code_req  = 1'b1;
        waited    = 0;
        do begin
            next_cycle();
            waited++;
        end while (code_ack !== 1'b1 && waited < 16);
        if (code_ack !== 1'b1) abort_run($sformatf("byte %02h was never acknowledged", code));
        code_req = 1'b0;
        waited   = 0;
        do begin
            next_cycle();
            waited++;
        end while (code_ack !== 1'b0 && waited < 16);
        if (code_ack !== 1'b0) abort_run("code_ack did not fall after code_req dropped");
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(2, 0)) next_cycle();
    endtask

    // make code followed by the break sequence
    task automatic tap_key(input logic [7:0] code);
        send_byte(code);
        idle_gap();
        send_byte(SCAN_BREAK);
        send_byte(code);
        idle_gap();
    endtask

    // main row or keypad code picked at random
    task automatic press_digit(input int value);
        tap_key(DIGIT_SCAN_CODES[$urandom_range(1, 0) * 10 + value]);
    endtask

    ////////////////////////////////////////////////////////////
    // game helpers
    ////////////////////////////////////////////////////////////

    // the next edge samples start
    // the counter at that edge is edge_count mod 98
    task automatic start_game();
        start  = 1'b1;
        answer = to_bcd((edge_count % 98) + 1);
        next_cycle();
        start = 1'b0;
        lower = LOWER_START;
        upper = UPPER_START;
    endtask

    task automatic check_bounds_shown();
        bcd_guess_t shown;
        read_pair(3, shown);
        check_value("lower bound", shown, lower);
        read_pair(1, shown);
        check_value("upper bound", shown, upper);
    endtask

    task automatic expect_dark(input string what, input logic [NUM_DIGITS-1:0] lines);
        int seen;
        seen = 0;
        repeat (2 * SCAN_DIV * NUM_DIGITS) begin
            next_cycle();
            if ((~digit & lines) != '0) seen++;
        end
        check_flag(what, seen == 0, 1'b1);
    endtask

    // enter on the typed pair and compare with the rule
    task automatic judge_entered(input bcd_guess_t guess);
        logic       won;
        bcd_guess_t new_lower;
        bcd_guess_t new_upper;
        bcd_guess_t shown;
        tap_key(SCAN_ENTER);
        won   = judge_guess(answer, guess, lower, upper, new_lower, new_upper);
        lower = new_lower;
        upper = new_upper;
        check_flag("win", win, won);
        if (won) begin
            read_pair(3, shown);
            check_value("answer on left digits", shown, answer);
            read_pair(1, shown);
            check_value("answer on right digits", shown, answer);
        end else begin
            check_bounds_shown();
        end
    endtask

    task automatic submit_guess(input bcd_guess_t guess);
        press_digit(guess.bcd.tens);
        press_digit(guess.bcd.ones);
        judge_entered(guess);
    endtask

    // random pair that is not the answer
    function automatic bcd_guess_t pick_miss();
        bcd_guess_t g;
        g = to_bcd($urandom_range(99, 0));
        if (g.raw == answer.raw) g = lower;
        return g;
    endfunction

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "mismatch");
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [6:0]  seg;
        bcd_guess_t  shown;
        bcd_guess_t  pair;
        int          d1;
        int          d2;

        void'($urandom(32'hbb4c));
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        cheat     = 1'b0;
        scan_code = 8'h00;
        code_req  = 1'b0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        err_mark  = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        // reset state and idle dashes
        check_flag("code_ack after reset", code_ack, 1'b0);
        check_flag("win after reset", win, 1'b0);
        check_flag("all digit lines dark", digit == '1, 1'b1);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            sample_digit(i, seg);
            check_segments($sformatf("idle digit %0d", i), seg, SEG_PATTERNS[10]);
        end
        report_test("reset and idle display");

        start_game();
        check_flag("win after start", win, 1'b0);
        check_bounds_shown();
        cheat = 1'b1;
        read_pair(3, shown);
        check_value("answer under cheat", shown, answer);
        expect_dark("right digits under cheat", 4'b0011);
        cheat = 1'b0;
        report_test("start and cheat view");

        d1   = $urandom_range(9, 0);
        d2   = $urandom_range(9, 0);
        pair = to_bcd(d1 * 10 + d2);
        if (pair.raw == answer.raw) begin
            d2   = (d2 + 1) % 10;
            pair = to_bcd(d1 * 10 + d2);
        end
        press_digit(d1);
        expect_dark("left digits after one press", 4'b1110);
        sample_digit(0, seg);
        check_segments("first typed digit", seg, SEG_PATTERNS[d1]);
        press_digit(d2);
        expect_dark("left digits after two presses", 4'b1100);
        read_pair(1, shown);
        check_value("typed pair", shown, pair);
        // extended make, extended break, unknown code, released enter
        send_byte(SCAN_EXTEND);
        send_byte(DIGIT_SCAN_CODES[13]);
        send_byte(SCAN_EXTEND);
        send_byte(SCAN_BREAK);
        send_byte(DIGIT_SCAN_CODES[13]);
        send_byte(8'h1C);
        send_byte(SCAN_BREAK);
        send_byte(SCAN_ENTER);
        read_pair(1, shown);
        check_value("pair after ignored codes", shown, pair);
        expect_dark("left digits after ignored codes", 4'b1100);
        judge_entered(pair);
        report_test("digit entry and ignored codes");

        submit_guess(lower);
        for (int n = 0; n < 10; n++) begin
            submit_guess(pick_miss());
        end
        report_test("bound narrowing");

        submit_guess(answer);
        start_game();
        check_flag("win after restart", win, 1'b0);
        check_bounds_shown();
        cheat = 1'b1;
        read_pair(3, shown);
        check_value("new answer under cheat", shown, answer);
        cheat = 1'b0;
        report_test("win and restart");

        submit_guess(pick_miss());
        press_digit($urandom_range(9, 0));
        tap_key(SCAN_ENTER);
        check_flag("win after single digit", win, 1'b0);
        check_bounds_shown();
        report_test("enter after one digit");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
hdl/guess_pkg.sv
hdl/key_event_if.sv
hdl/scan_code_decoder.sv
hdl/guess_game.sv
hdl/seg_scan.sv
hdl/guess_top.sv
bench/guess_tb.sv

/* hdl/guess_game.sv */
`timescale 1ns/1ns

module guess_game
    import guess_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        cheat,
    key_event_if.sink                   key,
    output logic                        win,
    output logic [NUM_DIGITS-1:0][3:0]  digits,
    output logic [NUM_DIGITS-1:0]       digit_mask
);

    game_state_t state;
    bcd_guess_t  counter;
    bcd_guess_t  answer;
    bcd_guess_t  lower;
    bcd_guess_t  upper;
    bcd_guess_t  entry;
    logic        start_d;
    logic        new_game;
    logic        digit_in;
    logic        enter_in;

    function automatic bcd_guess_t bcd_step(bcd_guess_t v);
        bcd_guess_t r;
        r = v;
        if (v.bcd.ones == 4'd9) begin
            r.bcd.ones = 4'd0;
            r.bcd.tens = v.bcd.tens + 4'd1;
        end else begin
            r.bcd.ones = v.bcd.ones + 4'd1;
        end
        return r;
    endfunction

    assign new_game = start && !start_d && (state == ST_IDLE || state == ST_WIN);
    assign digit_in = key.valid && key.is_digit;
    assign enter_in = key.valid && key.is_enter;
    assign win      = (state == ST_WIN);

    ////////////////////////////////////////////////////////////
    // free-running answer source
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter <= '0;
            start_d <= 1'b0;
        end else begin
            counter <= (counter.raw == ANSWER_WRAP) ? bcd_guess_t'('0) : bcd_step(counter);
            start_d <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (new_game) begin
            answer <= bcd_step(counter);
        end
        // last two typed digits
        if (digit_in) begin
            entry <= {entry.bcd.ones, key.digit};
        end
    end

    ////////////////////////////////////////////////////////////
    // game FSM and bounds
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            lower <= LOWER_START;
            upper <= UPPER_START;
        end else begin
            case (state)
                ST_IDLE, ST_WIN: begin
                    if (new_game) begin
                        state <= ST_RANGE;
                        lower <= LOWER_START;
                        upper <= UPPER_START;
                    end
                end
                ST_RANGE: begin
                    if (digit_in) state <= ST_ENTRY_ONE;
                end
                ST_ENTRY_ONE: begin
                    if (enter_in) state <= ST_RANGE;
                    else if (digit_in) state <= ST_ENTRY_TWO;
                end
                ST_ENTRY_TWO: begin
                    if (enter_in) begin
                        state <= ST_RANGE;
                        // only guesses strictly inside the bounds count
                        if (entry.raw > lower.raw && entry.raw < upper.raw) begin
                            if (entry.raw == answer.raw) state <= ST_WIN;
                            else if (entry.raw > answer.raw) upper <= entry;
                            else lower <= entry;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // display content, digits[3] is the leftmost
    always_comb begin
        digits     = {NUM_DIGITS{SEG_BLANK_CODE}};
        digit_mask = '1;
        case (state)
            ST_RANGE: begin
                if (cheat) begin
                    digits     = {answer.bcd.tens, answer.bcd.ones,
                                  SEG_BLANK_CODE, SEG_BLANK_CODE};
                    digit_mask = 4'b1100;
                end else begin
                    digits = {lower.bcd.tens, lower.bcd.ones,
                              upper.bcd.tens, upper.bcd.ones};
                end
            end
            ST_ENTRY_ONE: begin
                digits[0]  = entry.bcd.ones;
                digit_mask = 4'b0001;
            end
            ST_ENTRY_TWO: begin
                digits[1]  = entry.bcd.tens;
                digits[0]  = entry.bcd.ones;
                digit_mask = 4'b0011;
            end
            ST_WIN: begin
                digits = {answer.bcd.tens, answer.bcd.ones,
                          answer.bcd.tens, answer.bcd.ones};
            end
            default: ;
        endcase
    end

endmodule

/* hdl/guess_pkg.sv */
package guess_pkg;

    ////////////////////////////////////////////////////////////
    // guess value, one byte seen as raw or as two bcd nibbles
    ////////////////////////////////////////////////////////////

    // bcd order equals binary order, so raw compares directly
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] tens;
            logic [3:0] ones;
        } bcd;
    } bcd_guess_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RANGE,
        ST_ENTRY_ONE,
        ST_ENTRY_TWO,
        ST_WIN
    } game_state_t;

    ////////////////////////////////////////////////////////////
    // keyboard codes
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] SCAN_BREAK  = 8'hF0;
    localparam logic [7:0] SCAN_EXTEND = 8'hE0;
    localparam logic [7:0] SCAN_ENTER  = 8'h5A;

    localparam int NUM_DIGIT_CODES = 20;

    // main row 0..9, then keypad 0..9
    localparam logic [7:0] DIGIT_SCAN_CODES [NUM_DIGIT_CODES] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
        8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
    };

    // game limits
    localparam logic [7:0] ANSWER_WRAP = 8'h97;
    localparam logic [7:0] LOWER_START = 8'h00;
    localparam logic [7:0] UPPER_START = 8'h99;

    ////////////////////////////////////////////////////////////
    // display
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] SEG_BLANK_CODE = 4'hF;

    // active low segments, gfedcba; last entry is the dash
    localparam logic [6:0] SEG_PATTERNS [11] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000,
        7'b0111111
    };

    localparam int SCAN_DIV   = 4;
    localparam int SCAN_DIV_W = $clog2(SCAN_DIV);
    localparam int NUM_DIGITS = 4;

endpackage

/* hdl/guess_top.sv */
`timescale 1ns/1ns

module guess_top
    import guess_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   cheat,
    input  logic [7:0]             scan_code,
    input  logic                   code_req,
    output logic                   code_ack,
    output logic                   win,
    output logic [NUM_DIGITS-1:0]  digit,
    output logic [6:0]             display
);

    logic [NUM_DIGITS-1:0][3:0] digits;
    logic [NUM_DIGITS-1:0]      digit_mask;

    key_event_if key_bus ();

    scan_code_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .scan_code (scan_code),
        .code_req  (code_req),
        .code_ack  (code_ack),
        .key       (key_bus.source)
    );

    guess_game u_game (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cheat      (cheat),
        .key        (key_bus.sink),
        .win        (win),
        .digits     (digits),
        .digit_mask (digit_mask)
    );

    seg_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .digits     (digits),
        .digit_mask (digit_mask),
        .digit      (digit),
        .display    (display)
    );

endmodule

/* hdl/key_event_if.sv */
`timescale 1ns/1ns

// decoded key press, valid is a one-clock pulse
interface key_event_if;
    logic       valid;
    logic       is_digit;
    logic       is_enter;
    logic [3:0] digit;

    modport source (output valid, output is_digit, output is_enter, output digit);

    modport sink (input valid, input is_digit, input is_enter, input digit);

endinterface

/* hdl/scan_code_decoder.sv */
`timescale 1ns/1ns

module scan_code_decoder
    import guess_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        scan_code,
    input  logic              code_req,
    output logic              code_ack,
    key_event_if.source       key
);

    logic       take;
    logic       brk_seen;
    logic       ext_seen;
    logic       hit_digit;
    logic       hit_enter;
    logic [3:0] hit_value;
    logic       make_event;

    // new byte on the port, not yet acknowledged
    assign take = code_req && !code_ack;

    ////////////////////////////////////////////////////////////
    // code lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        hit_digit = 1'b0;
        hit_value = '0;
        for (int i = 0; i < NUM_DIGIT_CODES; i++) begin
            if (scan_code == DIGIT_SCAN_CODES[i]) begin
                hit_digit = 1'b1;
                hit_value = 4'(i % 10);
            end
        end
    end

    assign hit_enter = (scan_code == SCAN_ENTER);

    // plain make code only, prefixed bytes are swallowed
    assign make_event = take && !brk_seen && !ext_seen && (hit_digit || hit_enter);

    ////////////////////////////////////////////////////////////
    // handshake and prefix flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code_ack  <= 1'b0;
            brk_seen  <= 1'b0;
            ext_seen  <= 1'b0;
            key.valid <= 1'b0;
        end else begin
            key.valid <= make_event;
            if (take) begin
                code_ack <= 1'b1;
                if (scan_code == SCAN_BREAK) begin
                    brk_seen <= 1'b1;
                end else if (scan_code == SCAN_EXTEND) begin
                    ext_seen <= 1'b1;
                end else begin
                    brk_seen <= 1'b0;
                    ext_seen <= 1'b0;
                end
            end else if (!code_req) begin
                code_ack <= 1'b0;
            end
        end
    end

    // event payload
    always_ff @(posedge clk) begin
        if (make_event) begin
            key.is_digit <= hit_digit;
            key.is_enter <= hit_enter;
            key.digit    <= hit_value;
        end
    end

endmodule

/* hdl/seg_scan.sv */
`timescale 1ns/1ns

module seg_scan
    import guess_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [NUM_DIGITS-1:0][3:0]  digits,
    input  logic [NUM_DIGITS-1:0]       digit_mask,
    output logic [NUM_DIGITS-1:0]       digit,
    output logic [6:0]                  display
);

    logic [SCAN_DIV_W-1:0] presc;
    logic [NUM_DIGITS-1:0] pos;
    logic [NUM_DIGITS-1:0] base;
    logic [NUM_DIGITS-1:0] cand;
    logic [NUM_DIGITS-1:0] next_pos;
    logic [3:0]            nib;

    // walk right to left until an enabled digit is found
    always_comb begin
        base     = (pos == '0) ? {1'b1, {(NUM_DIGITS-1){1'b0}}} : pos;
        cand     = base;
        next_pos = '0;
        for (int k = 0; k < NUM_DIGITS; k++) begin
            cand = {cand[NUM_DIGITS-2:0], cand[NUM_DIGITS-1]};
            if (next_pos == '0 && (cand & digit_mask) != '0) next_pos = cand;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc <= '0;
            pos   <= '0;
        end else if (presc == SCAN_DIV_W'(SCAN_DIV - 1)) begin
            presc <= '0;
            pos   <= next_pos;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // a digit disabled mid-step goes dark at once
    assign digit = ~(pos & digit_mask);

    always_comb begin
        nib = SEG_BLANK_CODE;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (pos[i]) nib = digits[i];
        end
    end

    // anything above 9 is a dash
    assign display = (nib > 4'd9) ? SEG_PATTERNS[10] : SEG_PATTERNS[nib];

endmodule
